//--- verilog/mc_pkg.sv
// mc_pkg
// shared definitions for the host-to-tile memory fabric:
// word width, operation codes and the request and response packets

package mc_pkg;

  // word width of every data path
  localparam int data_width_c = 32;

  // remote operations a tile can execute
  typedef enum logic [1:0] {
    op_store = 2'd0,
    op_load  = 2'd1,
    op_add   = 2'd2   // fetch-and-add, returns old word
  } mc_op_e;

  // host request packet
  typedef struct packed {
    mc_op_e                  op;
    logic [7:0]              x_cord;  // tile index
    logic [15:0]             addr;    // word address
    logic [data_width_c-1:0] data;
  } mc_req_s;

  // tile response packet
  typedef struct packed {
    logic [7:0]              x_cord;  // responding tile
    logic [data_width_c-1:0] data;
  } mc_rsp_s;

endpackage

//--- verilog/mc_init_seq.sv
// mc_init_seq
// sweeps zeros into every tile memory after reset, then holds
// the tiles in reset through a short stage chain before raising ready

`timescale 1ns/100ps

module mc_init_seq #(
  parameter int dmem_size_p   = 64,
  parameter int reset_depth_p = 3
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  output logic        clr_v_o,
  output logic [15:0] clr_addr_o,
  output logic        tile_reset_o,
  output logic        ready_o
);

  logic [15:0]              clr_cnt_r;
  logic                     clr_done_r;
  logic [reset_depth_p-1:0] rst_chain_r;

  // clear sweep, one word per cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clr_cnt_r  <= '0;
      clr_done_r <= 1'b0;
    end else if (!clr_done_r) begin
      if (clr_cnt_r == 16'(dmem_size_p - 1)) begin
        clr_done_r <= 1'b1;
      end else begin
        clr_cnt_r <= clr_cnt_r + 16'd1;
      end
    end
  end

  assign clr_v_o    = ~clr_done_r;
  assign clr_addr_o = clr_cnt_r;

  // release chain, shifts in ~done
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_chain_r <= '1;  // tiles held in reset
    end else begin
      rst_chain_r[0] <= ~clr_done_r;
      for (int i = 1; i < reset_depth_p; i++) begin
        rst_chain_r[i] <= rst_chain_r[i-1];
      end
    end
  end

  assign tile_reset_o = rst_chain_r[reset_depth_p-1];
  assign ready_o      = ~rst_chain_r[reset_depth_p-1];

endmodule

//--- verilog/mc_request_router.sv
// mc_request_router
// registers each host request and strobes the addressed tile,
// or pulses error_o for an out-of-range tile index

`timescale 1ns/100ps

module mc_request_router #(
  parameter int num_tiles_p = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_v_i,
  input  mc_pkg::mc_req_s        req_i,
  output logic [num_tiles_p-1:0] tile_v_o,
  output mc_pkg::mc_req_s        tile_req_o,
  output logic                   error_o
);

  import mc_pkg::*;

  logic [num_tiles_p-1:0] tile_v_n;
  logic                   error_n;
  logic [num_tiles_p-1:0] tile_v_r;
  logic                   error_r;
  mc_req_s                req_r;

  // one-hot decode of x_cord
  always_comb begin
    for (int i = 0; i < num_tiles_p; i++) begin
      tile_v_n[i] = req_v_i && (int'(req_i.x_cord) == i);
    end
    error_n = req_v_i && (int'(req_i.x_cord) >= num_tiles_p);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tile_v_r <= '0;
      error_r  <= 1'b0;
    end else begin
      tile_v_r <= tile_v_n;
      error_r  <= error_n;  // single-cycle pulse
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i) req_r <= req_i;
  end

  assign tile_v_o   = tile_v_r;
  assign tile_req_o = req_r;
  assign error_o    = error_r;

endmodule

//--- verilog/mc_tile.sv
// mc_tile
// word-addressed data memory of one tile, executes store, load and
// fetch-and-add and returns a registered response tagged with its index

`timescale 1ns/100ps

module mc_tile #(
  parameter int x_cord_p    = 0,
  parameter int dmem_size_p = 64
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            tile_reset_i,
  input  logic            clr_v_i,
  input  logic [15:0]     clr_addr_i,
  input  logic            req_v_i,
  input  mc_pkg::mc_req_s req_i,
  output logic            rsp_v_o,
  output mc_pkg::mc_rsp_s rsp_o,
  output logic            store_done_o
);

  import mc_pkg::*;

  localparam int addr_width_lp = (dmem_size_p > 1) ? $clog2(dmem_size_p) : 1;

  logic [data_width_c-1:0]  mem_r [dmem_size_p];
  logic [addr_width_lp-1:0] word_addr;
  logic [data_width_c-1:0]  old_word;
  logic                     exec_v;
  logic                     rsp_v_r;
  logic                     store_done_r;
  logic [data_width_c-1:0]  rsp_data_r;

  assign exec_v    = req_v_i & ~tile_reset_i;
  assign word_addr = req_i.addr[addr_width_lp-1:0];  // modulo dmem size
  assign old_word  = mem_r[word_addr];

  always_ff @(posedge clk_i) begin
    if (clr_v_i) begin
      mem_r[clr_addr_i[addr_width_lp-1:0]] <= '0;
    end else if (exec_v) begin
      case (req_i.op)
        op_store: mem_r[word_addr] <= req_i.data;
        op_add:   mem_r[word_addr] <= old_word + req_i.data;  // wraps at 32 bits
        default:  ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_v_r      <= 1'b0;
      store_done_r <= 1'b0;
    end else begin
      rsp_v_r      <= exec_v && (req_i.op == op_load || req_i.op == op_add);
      store_done_r <= exec_v && (req_i.op == op_store);
    end
  end

  // old word for load and add
  always_ff @(posedge clk_i) begin
    if (exec_v) rsp_data_r <= old_word;
  end

  assign rsp_v_o      = rsp_v_r;
  assign rsp_o        = '{x_cord: 8'(x_cord_p), data: rsp_data_r};
  assign store_done_o = store_done_r;

endmodule

//--- verilog/mc_response_merge.sv
// mc_response_merge
// funnels the single valid tile response onto one registered stream
// and counts completed stores

`timescale 1ns/100ps

module mc_response_merge #(
  parameter int num_tiles_p = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   tile_reset_i,
  input  logic [num_tiles_p-1:0] tile_rsp_v_i,
  input  mc_pkg::mc_rsp_s        tile_rsp_i [num_tiles_p],
  input  logic [num_tiles_p-1:0] store_done_i,
  output logic                   rsp_v_o,
  output mc_pkg::mc_rsp_s        rsp_o,
  output logic [15:0]            store_count_o
);

  import mc_pkg::*;

  logic        sel_v;
  mc_rsp_s     sel_rsp;
  logic [15:0] store_inc;
  logic        rsp_v_r;
  mc_rsp_s     rsp_r;
  logic [15:0] store_cnt_r;

  // at most one tile responds per cycle
  always_comb begin
    sel_v     = 1'b0;
    sel_rsp   = '0;
    store_inc = '0;
    for (int i = 0; i < num_tiles_p; i++) begin
      if (tile_rsp_v_i[i]) begin
        sel_v   = 1'b1;
        sel_rsp = tile_rsp_i[i];
      end
      store_inc = store_inc + 16'(store_done_i[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_v_r     <= 1'b0;
      store_cnt_r <= '0;
    end else begin
      rsp_v_r     <= sel_v & ~tile_reset_i;
      store_cnt_r <= tile_reset_i ? '0 : store_cnt_r + store_inc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_v) rsp_r <= sel_rsp;
  end

  assign rsp_v_o       = rsp_v_r;
  assign rsp_o         = rsp_r;
  assign store_count_o = store_cnt_r;

endmodule

//--- verilog/mc_top.sv
// mc_top
// host-to-tile memory fabric: init sequencer, request router,
// num_tiles_p data-memory tiles and the response merge

`timescale 1ns/100ps

module mc_top #(
  parameter int num_tiles_p   = 4,
  parameter int dmem_size_p   = 64,
  parameter int reset_depth_p = 3
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_v_i,
  input  mc_pkg::mc_req_s req_i,
  output logic            ready_o,
  output logic            rsp_v_o,
  output mc_pkg::mc_rsp_s rsp_o,
  output logic            error_o,
  output logic [15:0]     store_count_o
);

  import mc_pkg::*;

  logic                   clr_v;
  logic [15:0]            clr_addr;
  logic                   tile_reset;
  logic [num_tiles_p-1:0] tile_v;
  mc_req_s                tile_req;
  logic [num_tiles_p-1:0] tile_rsp_v;
  mc_rsp_s                tile_rsp [num_tiles_p];
  logic [num_tiles_p-1:0] store_done;

  mc_init_seq #(
    .dmem_size_p  (dmem_size_p),
    .reset_depth_p(reset_depth_p)
  ) init_seq (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clr_v_o     (clr_v),
    .clr_addr_o  (clr_addr),
    .tile_reset_o(tile_reset),
    .ready_o     (ready_o)
  );

  mc_request_router #(
    .num_tiles_p(num_tiles_p)
  ) router (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_v_i   (req_v_i),
    .req_i     (req_i),
    .tile_v_o  (tile_v),
    .tile_req_o(tile_req),
    .error_o   (error_o)
  );

  // one tile per x coordinate
  for (genvar i = 0; i < num_tiles_p; i++) begin : tile_gen
    mc_tile #(
      .x_cord_p   (i),
      .dmem_size_p(dmem_size_p)
    ) tile (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .tile_reset_i(tile_reset),
      .clr_v_i     (clr_v),
      .clr_addr_i  (clr_addr),
      .req_v_i     (tile_v[i]),
      .req_i       (tile_req),
      .rsp_v_o     (tile_rsp_v[i]),
      .rsp_o       (tile_rsp[i]),
      .store_done_o(store_done[i])
    );
  end

  mc_response_merge #(
    .num_tiles_p(num_tiles_p)
  ) merge (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tile_reset_i (tile_reset),
    .tile_rsp_v_i (tile_rsp_v),
    .tile_rsp_i   (tile_rsp),
    .store_done_i (store_done),
    .rsp_v_o      (rsp_v_o),
    .rsp_o        (rsp_o),
    .store_count_o(store_count_o)
  );

endmodule

//--- testbench/mc_clock_gen.sv
// mc_clock_gen
// testbench clock and power-on reset

`timescale 1ns/100ps

module mc_clock_gen #(
  parameter int period_p       = 10,
  parameter int reset_cycles_p = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // release just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

//--- testbench/mc_properties.sv
// mc_properties
// protocol and latency checks on the top-level ports of the fabric

`timescale 1ns/100ps

module mc_properties #(
  parameter int num_tiles_p = 4
) (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            req_v_i,
  input mc_pkg::mc_req_s req_i,
  input logic            ready_o,
  input logic            rsp_v_o,
  input logic            error_o
);

  import mc_pkg::*;

  logic fetch_v;  // load or add to a real tile

  assign fetch_v = req_v_i && (int'(req_i.x_cord) < num_tiles_p)
                   && (req_i.op == op_load || req_i.op == op_add);

  req_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_v_i |-> ready_o)
    else $error("request sent while ready_o low");

  error_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    error_o |=> !error_o)
    else $error("error_o held longer than one cycle");

  // fixed three cycle load path
  rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_v_o == $past(fetch_v, 3))
    else $error("rsp_v_o not three cycles after a load or add");

  rsp_vs_error: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(rsp_v_o && error_o))
    else $error("rsp_v_o and error_o high together");

endmodule

bind mc_top mc_properties #(.num_tiles_p(num_tiles_p)) props (
  .clk_i  (clk_i),
  .rst_n_i(rst_n_i),
  .req_v_i(req_v_i),
  .req_i  (req_i),
  .ready_o(ready_o),
  .rsp_v_o(rsp_v_o),
  .error_o(error_o)
);

//--- testbench/mc_tb.sv
// mc_tb
// testbench for the host-to-tile memory fabric: directed requests from
// a stimulus file, then back-to-back random traffic against a model

`timescale 1ns/100ps

module mc_tb;

  import mc_pkg::*;

  localparam int num_tiles_c    = 4;
  localparam int dmem_size_c    = 64;
  localparam int reset_depth_c  = 3;
  localparam int reset_cycles_c = 16;
  localparam int max_lines_c    = 64;
  localparam int random_reqs_c  = 200;

  typedef struct packed {
    int                      due;  // cycle the response must show up
    logic [7:0]              x_cord;
    logic [data_width_c-1:0] data;
  } exp_rsp_s;

  logic                    clk;
  logic                    rst_n;
  logic                    req_v;
  mc_req_s                 req;
  logic                    ready;
  logic                    rsp_v;
  mc_rsp_s                 rsp;
  logic                    error;
  logic [15:0]             store_count;
  logic [31:0]             stim_mem [max_lines_c*6];
  logic [data_width_c-1:0] model_mem [num_tiles_c][dmem_size_c];
  exp_rsp_s                rsp_q [$];
  string                   name_q [$];
  int                      err_q [$];
  int                      rsp_head = 0;
  int                      err_head = 0;
  int                      cyc = 0;
  int                      stores_issued;
  int                      n_lines;
  int                      watchdog_cycles;
  logic                    lines_loaded = 1'b0;
  logic [31:0]             lcg_state;
  exp_rsp_s                got;

  mc_clock_gen #(
    .period_p      (10),
    .reset_cycles_p(reset_cycles_c)
  ) clock_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  mc_top dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_v_i      (req_v),
    .req_i        (req),
    .ready_o      (ready),
    .rsp_v_o      (rsp_v),
    .rsp_o        (rsp),
    .error_o      (error),
    .store_count_o(store_count)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // reference memory, returns the word before the operation
  function automatic logic [31:0] update_model(input mc_op_e op, input logic [7:0] x,
                                               input logic [15:0] addr,
                                               input logic [31:0] data);
    int          a;
    logic [31:0] old;
    a   = int'(addr) % dmem_size_c;
    old = model_mem[int'(x)][a];
    case (op)
      op_store: model_mem[int'(x)][a] = data;
      op_add:   model_mem[int'(x)][a] = old + data;
      default:  ;
    endcase
    return old;
  endfunction

  task automatic send_request(input mc_op_e op, input logic [7:0] x, input logic [15:0] addr,
                              input logic [31:0] data, input logic has_rsp,
                              input logic [31:0] rsp_data, input string name);
    exp_rsp_s e;
    req_v = 1'b1;
    req   = '{op: op, x_cord: x, addr: addr, data: data};
    if (int'(x) >= num_tiles_c) begin
      err_q.push_back(cyc + 1);  // router flags it next cycle
    end else begin
      if (op == op_store) stores_issued++;
      if (has_rsp) begin
        e.due    = cyc + 3;
        e.x_cord = x;
        e.data   = rsp_data;
        rsp_q.push_back(e);
        name_q.push_back(name);
      end
    end
    @(posedge clk);
    #1;
    req_v = 1'b0;
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(posedge rst_n);
    while (ready !== 1'b1) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > 4 * (dmem_size_c + reset_depth_c)) begin
        abort_run("ready never rose after reset");
      end
    end
    check_value("ready delay", 32'(dmem_size_c + reset_depth_c), 32'(cycles));
  endtask

  task automatic run_directed();
    mc_op_e      op;
    logic [7:0]  x;
    logic [15:0] addr;
    logic [31:0] data;
    for (int i = 0; i < n_lines; i++) begin
      op   = mc_op_e'(stim_mem[i*6][1:0]);
      x    = stim_mem[i*6+1][7:0];
      addr = stim_mem[i*6+2][15:0];
      data = stim_mem[i*6+3];
      if (int'(x) < num_tiles_c) begin
        void'(update_model(op, x, addr, data));
      end
      send_request(op, x, addr, data, stim_mem[i*6+4][0], stim_mem[i*6+5],
                   $sformatf("directed line %0d", i));
    end
  endtask

  task automatic run_random();
    mc_op_e      op;
    logic [7:0]  x;
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] old;
    for (int i = 0; i < random_reqs_c; i++) begin
      op   = mc_op_e'(2'((lcg_next() >> 16) % 32'd3));
      x    = 8'((lcg_next() >> 16) % 32'(num_tiles_c));
      addr = 16'((lcg_next() >> 16) % 32'(2 * dmem_size_c));  // upper half wraps
      data = lcg_next();
      old  = update_model(op, x, addr, data);
      send_request(op, x, addr, data, op != op_store, old,
                   $sformatf("random request %0d", i));
    end
  endtask

  // responses and error pulses, sampled mid-cycle
  always @(posedge clk) cyc <= cyc + 1;

  always @(negedge clk) begin
    if (rst_n) begin
      if (rsp_v) begin
        if (rsp_head >= rsp_q.size()) begin
          abort_run("response arrived with none expected");
        end else begin
          got = rsp_q[rsp_head];
          check_value({name_q[rsp_head], " cycle"}, got.due, cyc);
          check_value({name_q[rsp_head], " x_cord"}, 32'(got.x_cord), 32'(rsp.x_cord));
          check_value({name_q[rsp_head], " data"}, got.data, rsp.data);
          rsp_head = rsp_head + 1;
        end
      end else if (rsp_head < rsp_q.size() && rsp_q[rsp_head].due <= cyc) begin
        abort_run("expected response never arrived");
      end
      if (error) begin
        if (err_head >= err_q.size()) begin
          abort_run("error pulse with no bad request");
        end else begin
          check_value("error pulse cycle", err_q[err_head], cyc);
          err_head = err_head + 1;
        end
      end else if (err_head < err_q.size() && err_q[err_head] <= cyc) begin
        abort_run("expected error pulse never arrived");
      end
    end
  end

  initial begin
    wait (lines_loaded === 1'b1);
    repeat (watchdog_cycles) @(posedge clk);
    abort_run("watchdog timeout, traffic did not finish in time");
  end

  initial begin
    req_v         = 1'b0;
    req           = '0;
    lcg_state     = 32'hc0a6;
    stores_issued = 0;
    for (int t = 0; t < num_tiles_c; t++) begin
      for (int a = 0; a < dmem_size_c; a++) model_mem[t][a] = '0;
    end
    for (int i = 0; i < max_lines_c * 6; i++) stim_mem[i] = '0;
    $readmemh("testbench/mc_stimulus.hex", stim_mem);
    n_lines = 0;
    while (n_lines < max_lines_c && stim_mem[n_lines*6] != 32'hff) n_lines++;
    if (n_lines == max_lines_c) abort_run("stimulus file has no end marker");
    watchdog_cycles = reset_cycles_c + dmem_size_c + reset_depth_c
                      + 4 * n_lines + 4 * random_reqs_c + 100;
    lines_loaded = 1'b1;

    repeat (4) @(posedge clk);
    #1;
    check_value("reset ready_o", 32'd0, 32'(ready));
    check_value("reset rsp_v_o", 32'd0, 32'(rsp_v));
    check_value("reset error_o", 32'd0, 32'(error));
    check_value("reset store_count_o", 32'd0, 32'(store_count));

    wait_ready();
    run_directed();
    run_random();

    while (rsp_head < rsp_q.size() || err_head < err_q.size()) @(posedge clk);
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("store count", 32'(stores_issued), 32'(store_count));

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- compile.f
verilog/mc_pkg.sv
verilog/mc_init_seq.sv
verilog/mc_request_router.sv
verilog/mc_tile.sv
verilog/mc_response_merge.sv
verilog/mc_top.sv
testbench/mc_clock_gen.sv
testbench/mc_properties.sv
testbench/mc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the memory fabric testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal --top-module mc_tb \
  --Mdir obj_dir -o mc_sim -f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/mc_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- testbench/mc_stimulus.hex
// op x_cord addr data expect_rsp expect_data, all hex
// op 0 store, 1 load, 2 fetch-and-add; op ff ends the list
// cleared memories read back zero
1 00 0000 00000000 1 00000000
1 01 0011 00000000 1 00000000
1 02 0022 00000000 1 00000000
1 03 003f 00000000 1 00000000
1 00 003f 00000000 1 00000000
1 03 0000 00000000 1 00000000
// store then load, tiles kept apart
0 00 0005 deadbeef 0 00000000
1 00 0005 00000000 1 deadbeef
0 01 0005 12345678 0 00000000
0 02 0005 a5a5a5a5 0 00000000
0 03 0005 0badf00d 0 00000000
1 01 0005 00000000 1 12345678
1 02 0005 00000000 1 a5a5a5a5
1 03 0005 00000000 1 0badf00d
1 00 0005 00000000 1 deadbeef
// fetch-and-add returns the old word
0 02 0010 00000064 0 00000000
2 02 0010 00000005 1 00000064
1 02 0010 00000000 1 00000069
0 03 0030 fffffffe 0 00000000
2 03 0030 00000005 1 fffffffe
1 03 0030 00000000 1 00000003
2 01 0007 00000001 1 00000000
2 01 0007 00000001 1 00000001
1 01 0007 00000000 1 00000002
// bad tile index, two stores ahead of each so no response lands on the pulse
0 00 0020 00000abc 0 00000000
0 01 0020 00000def 0 00000000
0 04 0005 ffffffff 0 00000000
1 00 0005 00000000 1 deadbeef
0 02 0020 00000123 0 00000000
0 03 0020 00000456 0 00000000
0 07 0010 11111111 0 00000000
1 02 0010 00000000 1 00000069
0 00 0021 00000007 0 00000000
0 01 0021 00000008 0 00000000
2 ff 0000 00000001 0 00000000
1 00 0000 00000000 1 00000000
1 00 0020 00000000 1 00000abc
1 03 0020 00000000 1 00000456
// addresses wrap modulo 64
0 01 0045 cafebabe 0 00000000
1 01 0005 00000000 1 cafebabe
1 01 ffc5 00000000 1 cafebabe
0 03 0080 00c0ffee 0 00000000
1 03 0000 00000000 1 00c0ffee
ff 00 0000 00000000 0 00000000
